//--- verilog/sramPkg.sv
`default_nettype none

package sramPkg;

    //////////////////////////////////////////////////
    // Memory geometry
    //////////////////////////////////////////////////

    localparam int numWord = 256;
    localparam int addrWidth = 8;
    // Word width, also the write mask width
    localparam int dataWidth = 32;

    // Highest word address, start point of a down sweep
    localparam logic [addrWidth-1:0] lastAddr = addrWidth'(numWord - 1);

    //////////////////////////////////////////////////
    // March C- sequence
    //////////////////////////////////////////////////

    localparam int marchElemCount = 6;

    // Listed in run order
    typedef enum logic [2:0] {
        upW0,
        upR0W1,
        upR1W0,
        downR0W1,
        downR1W0,
        upR0
    } marchElem_t;

    // Solid data backgrounds
    localparam logic [dataWidth-1:0] backgroundZero = '0;
    localparam logic [dataWidth-1:0] backgroundOne = '1;

endpackage

`default_nettype wire

//--- verilog/sramPortIf.sv
`default_nettype none

// One macro-style access port, all strobes active low
interface sramPortIf;

    logic ceb;
    logic web;
    logic [sramPkg::addrWidth-1:0] a;
    logic [sramPkg::dataWidth-1:0] d;
    // Per-bit write mask, low bits get written
    logic [sramPkg::dataWidth-1:0] bweb;

    // Side that issues operations
    modport master (output ceb, web, a, d, bweb);

    // Memory side
    modport array (input ceb, web, a, d, bweb);

endinterface

`default_nettype wire

//--- verilog/sramArray.sv
`default_nettype none

module sramArray (
    input  logic CLK,
    input  logic rstN,
    input  logic slp,
    input  logic sd,
    input  logic bistMode,
    sramPortIf.array normPort,
    sramPortIf.array bistPort,
    output logic [sramPkg::dataWidth-1:0] q
);

    // Storage array
    logic [sramPkg::dataWidth-1:0] mem [sramPkg::numWord];

    // Port after the test-mode mux
    logic selCeb;
    logic selWeb;
    logic [sramPkg::addrWidth-1:0] selA;
    logic [sramPkg::dataWidth-1:0] selD;
    logic [sramPkg::dataWidth-1:0] selBweb;

    logic access;
    logic [sramPkg::dataWidth-1:0] qReg;

    //////////////////////////////////////////////////
    // Port select
    //////////////////////////////////////////////////

    // BIST side owns the array for the whole run
    always_comb begin
        if (bistMode) begin
            selCeb = bistPort.ceb;
            selWeb = bistPort.web;
            selA = bistPort.a;
            selD = bistPort.d;
            selBweb = bistPort.bweb;
        end else begin
            selCeb = normPort.ceb;
            selWeb = normPort.web;
            selA = normPort.a;
            selD = normPort.d;
            selBweb = normPort.bweb;
        end
    end

    // Sleep and shutdown both block the access
    assign access = !selCeb && !slp && !sd;

    //////////////////////////////////////////////////
    // Array write
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (sd) begin
            // Power off, contents lost
            for (int i = 0; i < sramPkg::numWord; i++) begin
                mem[i] <= '0;
            end
        end else if (access && !selWeb) begin
            // Masked-out bits keep the old value
            mem[selA] <= (mem[selA] & selBweb) | (selD & ~selBweb);
        end
    end

    //////////////////////////////////////////////////
    // Read register
    //////////////////////////////////////////////////

    // Holds between reads and through sleep
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            qReg <= '0;
        end else if (sd) begin
            qReg <= '0;
        end else if (access && selWeb) begin
            qReg <= mem[selA];
        end
    end

    // Output reads zero as soon as sd is up
    assign q = sd ? '0 : qReg;

endmodule

`default_nettype wire

//--- verilog/bistAddrGen.sv
`default_nettype none

module bistAddrGen (
    input  logic CLK,
    input  logic rstN,
    input  logic addrClear,
    input  logic addrDown,
    input  logic addrStep,
    output logic [sramPkg::addrWidth-1:0] addr,
    output logic addrLast
);

    // Direction captured at clear, held for the sweep
    logic dirDown;

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            addr <= '0;
            dirDown <= 1'b0;
        end else if (addrClear) begin
            // Clear wins over a step in the same cycle
            addr <= addrDown ? sramPkg::lastAddr : '0;
            dirDown <= addrDown;
        end else if (addrStep) begin
            if (dirDown) begin
                addr <= addr - 1'b1;
            end else begin
                addr <= addr + 1'b1;
            end
        end
    end

    // Final address of the sweep
    assign addrLast = dirDown ? (addr == '0) : (addr == sramPkg::lastAddr);

endmodule

`default_nettype wire

//--- verilog/bistComparator.sv
`default_nettype none

module bistComparator (
    input  logic CLK,
    input  logic rstN,
    input  logic clear,
    input  logic cmpStrobe,
    input  logic [sramPkg::dataWidth-1:0] cmpExpect,
    input  logic [sramPkg::addrWidth-1:0] cmpAddr,
    input  logic [sramPkg::dataWidth-1:0] q,
    output logic bistFail,
    output logic [sramPkg::addrWidth-1:0] bistFailAddr
);

    // Issue-cycle values delayed to line up with q
    logic strobeD;
    logic [sramPkg::dataWidth-1:0] expectD;
    logic [sramPkg::addrWidth-1:0] addrD;

    logic mismatch;

    always_ff @(posedge CLK) begin
        expectD <= cmpExpect;
        addrD <= cmpAddr;
    end

    assign mismatch = strobeD && (q != expectD);

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            strobeD <= 1'b0;
            bistFail <= 1'b0;
            bistFailAddr <= '0;
        end else begin
            strobeD <= cmpStrobe;
            if (clear) begin
                bistFail <= 1'b0;
                bistFailAddr <= '0;
            end else if (mismatch && !bistFail) begin
                // First failure only, later ones ignored
                bistFail <= 1'b1;
                bistFailAddr <= addrD;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/bistController.sv
`default_nettype none

module bistController (
    input  logic CLK,
    input  logic rstN,
    input  logic bistStart,
    sramPortIf.master bistPort,
    output logic bistMode,
    output logic bistDone,
    output logic runStart,
    output logic addrClear,
    output logic addrDown,
    output logic addrStep,
    input  logic [sramPkg::addrWidth-1:0] addr,
    input  logic addrLast,
    output logic cmpStrobe,
    output logic [sramPkg::dataWidth-1:0] cmpExpect
);

    typedef enum logic [1:0] {
        stateIdle,
        stateRun,
        stateDrain
    } state_t;

    state_t state;
    sramPkg::marchElem_t elem;
    sramPkg::marchElem_t nextElem;
    sramPkg::marchElem_t loadElem;

    // Write half of a read-write pair
    logic inWrite;
    logic hasWrite;
    logic [sramPkg::dataWidth-1:0] readBg;
    logic [sramPkg::dataWidth-1:0] writeBg;
    logic opIssue;
    logic finalOp;
    logic elemLast;

    function automatic logic isDown(input sramPkg::marchElem_t e);
        return (e == sramPkg::downR0W1) || (e == sramPkg::downR1W0);
    endfunction

    //////////////////////////////////////////////////
    // Element decode
    //////////////////////////////////////////////////

    // Default is r0 then w1
    always_comb begin
        hasWrite = 1'b1;
        readBg = sramPkg::backgroundZero;
        writeBg = sramPkg::backgroundOne;
        case (elem)
            sramPkg::upW0: writeBg = sramPkg::backgroundZero;
            sramPkg::upR1W0, sramPkg::downR1W0: begin
                readBg = sramPkg::backgroundOne;
                writeBg = sramPkg::backgroundZero;
            end
            sramPkg::upR0: hasWrite = 1'b0;
            default: ;
        endcase
    end

    assign nextElem = sramPkg::marchElem_t'(elem + 3'd1);
    assign elemLast = elem == sramPkg::marchElem_t'(sramPkg::marchElemCount - 1);

    //////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////

    // Start only counts when idle
    assign runStart = (state == stateIdle) && bistStart;
    assign opIssue = state == stateRun;
    // Last operation on the current address
    assign finalOp = inWrite || !hasWrite;
    assign addrStep = opIssue && finalOp;
    // Reload counter at start and at each element boundary
    assign addrClear = runStart || (addrStep && addrLast && !elemLast);
    assign loadElem = runStart ? sramPkg::upW0 : nextElem;
    assign addrDown = isDown(loadElem);

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            state <= stateIdle;
            bistDone <= 1'b0;
            elem <= sramPkg::upW0;
            inWrite <= 1'b0;
        end else begin
            case (state)
                stateIdle: begin
                    if (bistStart) begin
                        state <= stateRun;
                        bistDone <= 1'b0;
                        elem <= sramPkg::upW0;
                        inWrite <= 1'b1;
                    end
                end
                stateRun: begin
                    if (!finalOp) begin
                        inWrite <= 1'b1;
                    end else if (!addrLast) begin
                        // Next address, same element
                        inWrite <= elem == sramPkg::upW0;
                    end else if (elemLast) begin
                        state <= stateDrain;
                    end else begin
                        elem <= nextElem;
                        inWrite <= nextElem == sramPkg::upW0;
                    end
                end
                // One cycle for the last read to reach the comparator
                default: begin
                    state <= stateIdle;
                    bistDone <= 1'b1;
                end
            endcase
        end
    end

    assign bistMode = state != stateIdle;

    //////////////////////////////////////////////////
    // BIST port and compare
    //////////////////////////////////////////////////

    assign bistPort.ceb = !opIssue;
    assign bistPort.web = !inWrite;
    assign bistPort.a = addr;
    assign bistPort.d = writeBg;
    // Full-word writes only
    assign bistPort.bweb = '0;

    assign cmpStrobe = opIssue && !inWrite;
    assign cmpExpect = readBg;

endmodule

`default_nettype wire

//--- verilog/sramSubsystem.sv
`default_nettype none

module sramSubsystem (
    input  logic CLK,
    input  logic rstN,
    input  logic slp,
    input  logic sd,
    input  logic ceb,
    input  logic web,
    input  logic [sramPkg::addrWidth-1:0] a,
    input  logic [sramPkg::dataWidth-1:0] d,
    input  logic [sramPkg::dataWidth-1:0] bweb,
    output logic [sramPkg::dataWidth-1:0] q,
    input  logic bistStart,
    output logic bistDone,
    output logic bistFail,
    output logic [sramPkg::addrWidth-1:0] bistFailAddr
);

    sramPortIf normPort ();
    sramPortIf bistPort ();

    logic bistMode;
    logic runStart;
    logic addrClear;
    logic addrDown;
    logic addrStep;
    logic addrLast;
    logic [sramPkg::addrWidth-1:0] bistAddr;
    logic cmpStrobe;
    logic [sramPkg::dataWidth-1:0] cmpExpect;

    // Normal-port pins into the bundle
    assign normPort.ceb = ceb;
    assign normPort.web = web;
    assign normPort.a = a;
    assign normPort.d = d;
    assign normPort.bweb = bweb;

    sramArray array_i (
        .CLK(CLK),
        .rstN(rstN),
        .slp(slp),
        .sd(sd),
        .bistMode(bistMode),
        .normPort(normPort.array),
        .bistPort(bistPort.array),
        .q(q)
    );

    bistController ctrl_i (
        .CLK(CLK),
        .rstN(rstN),
        .bistStart(bistStart),
        .bistPort(bistPort.master),
        .bistMode(bistMode),
        .bistDone(bistDone),
        .runStart(runStart),
        .addrClear(addrClear),
        .addrDown(addrDown),
        .addrStep(addrStep),
        .addr(bistAddr),
        .addrLast(addrLast),
        .cmpStrobe(cmpStrobe),
        .cmpExpect(cmpExpect)
    );

    bistAddrGen addrGen_i (
        .CLK(CLK),
        .rstN(rstN),
        .addrClear(addrClear),
        .addrDown(addrDown),
        .addrStep(addrStep),
        .addr(bistAddr),
        .addrLast(addrLast)
    );

    // Fail status cleared by an accepted start
    bistComparator cmp_i (
        .CLK(CLK),
        .rstN(rstN),
        .clear(runStart),
        .cmpStrobe(cmpStrobe),
        .cmpExpect(cmpExpect),
        .cmpAddr(bistAddr),
        .q(q),
        .bistFail(bistFail),
        .bistFailAddr(bistFailAddr)
    );

endmodule

`default_nettype wire

//--- bench/sramSubsystem_assertions.sv
`default_nettype none

module sramSubsystemChecker (
    input logic CLK,
    input logic rstN,
    input logic slp,
    input logic sd,
    input logic ceb,
    input logic web,
    input logic [sramPkg::addrWidth-1:0] a,
    input logic [sramPkg::dataWidth-1:0] d,
    input logic [sramPkg::dataWidth-1:0] bweb,
    input logic [sramPkg::dataWidth-1:0] q,
    input logic bistMode,
    input logic bistDone,
    input logic bistFail,
    input logic [sramPkg::addrWidth-1:0] bistFailAddr
);

    timeunit 1ns;
    timeprecision 100ps;

    // Upper bound on one March C- run
    localparam int runLimit = 2600;

    // Reference copy of the array
    logic [sramPkg::dataWidth-1:0] shadow [sramPkg::numWord];
    logic [sramPkg::dataWidth-1:0] qExpReg;
    int runCycles;
    // Failed checks so far for the testbench top to watch
    int errCount = 0;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Shutdown and a clean BIST run both end in zeros
    always_ff @(posedge CLK) begin
        if (sd || bistMode) begin
            for (int i = 0; i < sramPkg::numWord; i++) begin
                shadow[i] <= '0;
            end
        end else if (!ceb && !slp && !web) begin
            // Only bits with bweb low take new data
            for (int b = 0; b < sramPkg::dataWidth; b++) begin
                if (!bweb[b]) begin
                    shadow[a][b] <= d[b];
                end
            end
        end
    end

    // A run ends on a read of zero
    always_ff @(posedge CLK) begin
        if (!rstN || sd || bistMode) begin
            qExpReg <= '0;
        end else if (!ceb && !slp && web) begin
            qExpReg <= shadow[a];
        end
    end

    // Length of the current run
    always_ff @(posedge CLK) begin
        if (!rstN || !bistMode) begin
            runCycles <= 0;
        end else begin
            runCycles <= runCycles + 1;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    qMatch: assert property (@(posedge CLK) disable iff (!rstN)
            !bistMode && !sd |-> q == qExpReg)
        else begin
            errCount = errCount + 1;
            $error("** Error @%0t q: got %h, expected %h", $time, $sampled(q),
                $sampled(qExpReg));
        end

    sdZero: assert property (@(posedge CLK) disable iff (!rstN) sd |-> q == '0)
        else begin
            errCount = errCount + 1;
            $error("** Error @%0t q: got %h, expected 0 in shutdown", $time, $sampled(q));
        end

    doneClean: assert property (@(posedge CLK) disable iff (!rstN) bistDone |-> !bistFail)
        else begin
            errCount = errCount + 1;
            $error("** Error @%0t bistFail: got 1, expected 0", $time);
        end

    // No failing address after a clean run
    failAddrClean: assert property (@(posedge CLK) disable iff (!rstN)
            bistDone |-> bistFailAddr == '0)
        else begin
            errCount = errCount + 1;
            $error("** Error @%0t bistFailAddr: got %h, expected 00", $time,
                $sampled(bistFailAddr));
        end

    doneOnEnd: assert property (@(posedge CLK) disable iff (!rstN) $fell(bistMode) |-> bistDone)
        else begin
            errCount = errCount + 1;
            $error("** Error @%0t bistDone: got 0, expected 1 after the run", $time);
        end

    doneLowInRun: assert property (@(posedge CLK) disable iff (!rstN) bistMode |-> !bistDone)
        else begin
            errCount = errCount + 1;
            $error("** Error @%0t bistDone: got 1, expected 0 during the run", $time);
        end

    // A restarted run would overrun this
    runBound: assert property (@(posedge CLK) disable iff (!rstN)
            bistMode |-> runCycles < runLimit)
        else begin
            errCount = errCount + 1;
            $error("BIST run went on longer than %0d cycles", runLimit);
        end

endmodule

bind sramSubsystem sramSubsystemChecker checker_i (
    .CLK(CLK),
    .rstN(rstN),
    .slp(slp),
    .sd(sd),
    .ceb(ceb),
    .web(web),
    .a(a),
    .d(d),
    .bweb(bweb),
    .q(q),
    .bistMode(bistMode),
    .bistDone(bistDone),
    .bistFail(bistFail),
    .bistFailAddr(bistFailAddr)
);

`default_nettype wire

//--- bench/sramSubsystemTb.sv
`default_nettype none

module sramSubsystemTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod = 4;
    localparam int resetCycles = 16;
    // Random traffic stays in a small window so words get rewritten
    localparam int windowSize = 16;
    localparam int randomOps = 200;
    localparam int bistBound = 2600;
    // Reset, random traffic, three full sweeps, one run, slack
    localparam int cycleLimit = bistBound + resetCycles + 2 * randomOps
        + 3 * sramPkg::numWord + 200;
    localparam logic [31:0] seed = 32'h2a0f_cc82;

    logic CLK;
    logic rstN;
    logic slp;
    logic sd;
    logic ceb;
    logic web;
    logic [sramPkg::addrWidth-1:0] a;
    logic [sramPkg::dataWidth-1:0] d;
    logic [sramPkg::dataWidth-1:0] bweb;
    logic [sramPkg::dataWidth-1:0] q;
    logic bistStart;
    logic bistDone;
    logic bistFail;
    logic [sramPkg::addrWidth-1:0] bistFailAddr;
    int cycleCount = 0;

    sramSubsystem dut_i (
        .CLK(CLK),
        .rstN(rstN),
        .slp(slp),
        .sd(sd),
        .ceb(ceb),
        .web(web),
        .a(a),
        .d(d),
        .bweb(bweb),
        .q(q),
        .bistStart(bistStart),
        .bistDone(bistDone),
        .bistFail(bistFail),
        .bistFailAddr(bistFailAddr)
    );

    initial begin
        CLK = 1'b0;
        forever #(clkPeriod / 2) CLK = ~CLK;
    end

    //////////////////////////////////////////////////
    // Run limits
    //////////////////////////////////////////////////

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        wait (cycleCount >= cycleLimit);
        $display("TEST FAILED");
        $fatal(1, "Timeout, run did not finish within %0d cycles", cycleLimit);
    end

    // Stop at the first failed checker assertion
    initial begin
        wait (dut_i.checker_i.errCount != 0);
        $display("TEST FAILED");
        $fatal(1, "Checker assertion failed, see the error above");
    end

    //////////////////////////////////////////////////
    // Port tasks, all driven on the falling edge
    //////////////////////////////////////////////////

    task automatic writeWord(input logic [7:0] addr, input logic [31:0] data,
                             input logic [31:0] mask);
        @(negedge CLK);
        ceb = 1'b0;
        web = 1'b0;
        a = addr;
        d = data;
        bweb = mask;
    endtask

    task automatic readWord(input logic [7:0] addr);
        @(negedge CLK);
        ceb = 1'b0;
        web = 1'b1;
        a = addr;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge CLK);
            ceb = 1'b1;
            web = 1'b1;
        end
    endtask

    task automatic pulseStart();
        @(negedge CLK);
        ceb = 1'b1;
        bistStart = 1'b1;
        @(negedge CLK);
        bistStart = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(seed));
        rstN = 1'b0;
        slp = 1'b0;
        sd = 1'b0;
        ceb = 1'b1;
        web = 1'b1;
        a = '0;
        d = '0;
        bweb = '1;
        bistStart = 1'b0;
        repeat (resetCycles) @(negedge CLK);
        rstN = 1'b1;

        // Known contents first, then masked writes mixed with reads
        for (int i = 0; i < windowSize; i++) begin
            writeWord(8'(i), $urandom, '0);
        end
        for (int n = 0; n < randomOps; n++) begin
            if ($urandom_range(1) != 0) begin
                writeWord(8'($urandom_range(windowSize - 1)), $urandom, $urandom);
            end else begin
                readWord(8'($urandom_range(windowSize - 1)));
            end
        end
        for (int i = 0; i < windowSize; i++) begin
            readWord(8'(i));
        end

        // Deselected, q must hold
        repeat (8) begin
            @(negedge CLK);
            ceb = 1'b1;
            web = 1'($urandom_range(1));
            a = 8'($urandom);
            d = $urandom;
            bweb = $urandom;
        end

        // Light sleep blocks reads and writes
        readWord(8'd3);
        @(negedge CLK);
        ceb = 1'b1;
        slp = 1'b1;
        for (int i = 0; i < windowSize / 2; i++) begin
            writeWord(8'(i), $urandom, '0);
            readWord(8'(i + windowSize / 2));
        end
        @(negedge CLK);
        ceb = 1'b1;
        slp = 1'b0;
        for (int i = 0; i < windowSize; i++) begin
            readWord(8'(i));
        end

        // Shutdown drops everything
        @(negedge CLK);
        ceb = 1'b1;
        sd = 1'b1;
        writeWord(8'd2, $urandom, '0);
        readWord(8'd2);
        idle(2);
        @(negedge CLK);
        sd = 1'b0;
        for (int i = 0; i < sramPkg::numWord; i++) begin
            readWord(8'(i));
        end

        // BIST run with a stray start and normal writes in the middle
        idle(2);
        pulseStart();
        idle(100);
        pulseStart();
        for (int i = 0; i < 32; i++) begin
            writeWord(8'($urandom), $urandom, '0);
        end
        idle(1);
        do begin
            @(negedge CLK);
        end while (!bistDone);
        idle(2);
        for (int i = 0; i < sramPkg::numWord; i++) begin
            readWord(8'(i));
        end
        idle(3);

        if (dut_i.checker_i.errCount == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "Checker reported %0d failures", dut_i.checker_i.errCount);
        end
    end

endmodule

`default_nettype wire

//--- files.f
verilog/sramPkg.sv
verilog/sramPortIf.sv
verilog/sramArray.sv
verilog/bistAddrGen.sv
verilog/bistComparator.sv
verilog/bistController.sv
verilog/sramSubsystem.sv
bench/sramSubsystem_assertions.sv
bench/sramSubsystemTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run with Verilator, the log decides the result

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module sramSubsystemTb -f files.f -o simSram \
    || { echo "Build failed"; exit 1; }

./obj_dir/simSram +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
